/* filelist.f */
+incdir+verification
hdl/realign_pkg.sv
hdl/beat_queue.sv
hdl/source_ctrl.sv
hdl/stream_realigner.sv
hdl/stream_source.sv
verification/stream_source_tb.sv

/* hdl/beat_queue.sv */
// small circular FIFO with a payload type parameter, holds response words or side records
`default_nettype none
`timescale 1ns/1ps

module beat_queue #(
  parameter int unsigned DEPTH     = realign_pkg::QUEUE_DEPTH,
  parameter type         payload_t = realign_pkg::mem_rsp_t
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic push_i,
  input  payload_t  data_i,
  input  wire logic pop_i,
  output payload_t  data_o,  // head entry, valid while not empty
  output logic      empty_o,
  output logic      full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full_o | do_pop); // a full queue takes a word when one leaves
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1); // wrap
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      if (do_push & ~do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (do_pop & ~do_push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/realign_pkg.sv */
// shared widths, queue depth and record types for the realigning stream source, imported by all RTL
`default_nettype none

package realign_pkg;

  // datapath and address geometry
  localparam int unsigned DATA_WIDTH      = 32;                      // memory word and stream beat
  localparam int unsigned STRB_WIDTH      = DATA_WIDTH / 8;          // bytes per word
  localparam int unsigned ADDR_WIDTH      = 16;                      // byte address
  localparam int unsigned LEN_WIDTH       = 16;                      // job length in bytes
  localparam int unsigned OFFS_WIDTH      = $clog2(STRB_WIDTH);      // byte lane inside a word
  localparam int unsigned WORD_ADDR_WIDTH = ADDR_WIDTH - OFFS_WIDTH; // word address to memory
  localparam int unsigned SHIFT_WIDTH     = $clog2(DATA_WIDTH) + 1;  // bit shift, 0..DATA_WIDTH

  // queue depth, doubles as the cap on reads in flight
  localparam int unsigned QUEUE_DEPTH  = 4;
  localparam int unsigned CREDIT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  // one job as handed in with start
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base;      // first byte
    logic [LEN_WIDTH-1:0]  len_bytes; // never zero
  } job_cfg_t;

  // record that travels with every word read
  typedef struct packed {
    logic [OFFS_WIDTH-1:0] offset;    // base mod 4
    logic                  first;     // first read of the job
    logic                  last;      // last read of the job
    logic                  emit;      // read closes an output beat
    logic                  flush;     // one more beat comes from the held word alone
    logic [STRB_WIDTH-1:0] tail_strb; // strobe of the final beat
  } side_info_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } stream_beat_t;

endpackage

`default_nettype wire

/* hdl/source_ctrl.sv */
// job controller, splits a byte job into word reads with side records and limits reads in flight
`default_nettype none
`timescale 1ns/1ps

module source_ctrl (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic                                   start_i,
  input  wire realign_pkg::job_cfg_t                  cfg_i,
  output logic                                        mem_req_o,
  output logic [realign_pkg::WORD_ADDR_WIDTH-1:0]     mem_addr_o,
  input  wire logic                                   mem_gnt_i,
  output logic                                        side_push_o,
  output realign_pkg::side_info_t                     side_o,
  input  wire logic                                   pop_i,       // realigner consumed a word
  input  wire logic                                   last_beat_i, // final beat handed off
  output logic                                        busy_o,
  output logic                                        done_o
);
  import realign_pkg::*;

  logic                       req_active_q; // reads still to issue
  logic                       first_q;      // next read is the first
  logic                       busy_q;
  logic                       done_q;
  logic [CREDIT_WIDTH-1:0]    credit_q;     // reads granted but not yet popped
  logic [WORD_ADDR_WIDTH-1:0] addr_q;       // word counter
  logic [WORD_ADDR_WIDTH-1:0] last_word_q;  // word holding the final byte
  logic [OFFS_WIDTH-1:0]      offset_q;
  logic [STRB_WIDTH-1:0]      tail_strb_q;
  logic                       flush_job_q;  // reads equal beats, final beat from held word

  logic [LEN_WIDTH-1:0]  len_m1;
  logic [ADDR_WIDTH-1:0] end_addr;
  logic [OFFS_WIDTH-1:0] tail_rem;    // (len-1) mod 4
  logic [OFFS_WIDTH:0]   fit_sum;     // carry set when the tail spills into one more word
  logic [STRB_WIDTH-1:0] tail_strb_d;
  logic                  job_take;
  logic                  grant;
  logic                  at_last;

  assign job_take = start_i & ~busy_q; // jobs only accepted when idle
  assign len_m1   = cfg_i.len_bytes - LEN_WIDTH'(1);
  assign end_addr = cfg_i.base + ADDR_WIDTH'(len_m1);
  assign tail_rem = len_m1[OFFS_WIDTH-1:0];
  assign fit_sum  = {1'b0, cfg_i.base[OFFS_WIDTH-1:0]} + {1'b0, tail_rem};

  // low tail_rem+1 lanes valid on the final beat
  always_comb begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      tail_strb_d[i] = (i <= int'(tail_rem));
    end
  end

  // request only while a queue slot is guaranteed for the answer
  assign mem_req_o  = req_active_q & (credit_q < CREDIT_WIDTH'(QUEUE_DEPTH));
  assign mem_addr_o = addr_q;
  assign grant      = mem_req_o & mem_gnt_i;
  assign at_last    = (addr_q == last_word_q);

  // side record for the read in the request slot
  assign side_push_o      = grant;
  assign side_o.offset    = offset_q;
  assign side_o.first     = first_q;
  assign side_o.last      = at_last;
  assign side_o.emit      = ~(first_q & (offset_q != '0)); // misaligned first word is only stored
  assign side_o.flush     = at_last & flush_job_q;
  assign side_o.tail_strb = tail_strb_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_active_q <= 1'b0;
      first_q      <= 1'b0;
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= last_beat_i; // one cycle after the last beat
      if (job_take) begin
        req_active_q <= 1'b1;
        first_q      <= 1'b1;
        busy_q       <= 1'b1;
      end else begin
        if (grant) begin
          first_q <= 1'b0;
          if (at_last) req_active_q <= 1'b0; // whole range issued
        end
        if (last_beat_i) busy_q <= 1'b0;
      end
    end
  end

  // in-flight count, up on grant and down on pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      case ({grant, pop_i})
        2'b10:   credit_q <= credit_q + CREDIT_WIDTH'(1);
        2'b01:   credit_q <= credit_q - CREDIT_WIDTH'(1);
        default: credit_q <= credit_q; // both or neither
      endcase
    end
  end

  // job range, latched at start
  always_ff @(posedge clk_i) begin
    if (job_take) begin
      addr_q      <= cfg_i.base[ADDR_WIDTH-1:OFFS_WIDTH];
      last_word_q <= end_addr[ADDR_WIDTH-1:OFFS_WIDTH];
      offset_q    <= cfg_i.base[OFFS_WIDTH-1:0];
      tail_strb_q <= tail_strb_d;
      // same as reads == ceil(len/4) for a nonzero offset
      flush_job_q <= (cfg_i.base[OFFS_WIDTH-1:0] != '0) & ~fit_sum[OFFS_WIDTH];
    end else if (grant & ~at_last) begin
      addr_q <= addr_q + WORD_ADDR_WIDTH'(1);
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

/* hdl/stream_realigner.sv */
// realigning datapath, merges consecutive words into aligned beats and appends the flush beat
`default_nettype none
`timescale 1ns/1ps

module stream_realigner (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      rsp_empty_i,
  input  wire realign_pkg::mem_rsp_t     rsp_i,        // response queue head
  input  wire logic                      side_empty_i,
  input  wire realign_pkg::side_info_t   side_i,       // side queue head
  output logic                           pop_o,        // pops both queues together
  output logic                           out_valid_o,
  output realign_pkg::stream_beat_t      out_beat_o,
  input  wire logic                      out_ready_i,
  output logic                           last_beat_o
);
  import realign_pkg::*;

  logic [DATA_WIDTH-1:0] prev_q;       // word before the current one
  logic [OFFS_WIDTH-1:0] flush_offs_q; // offset for the pending flush beat
  logic [STRB_WIDTH-1:0] tail_strb_q;
  logic                  flush_pend_q; // flush beat owed after the last pop
  logic                  head_valid;
  logic                  head_last;    // head word closes the job's final beat

  // upper lanes of the held word land low, lower lanes of the new word land high
  function automatic logic [DATA_WIDTH-1:0] merge_words(
    input logic [DATA_WIDTH-1:0] held,
    input logic [DATA_WIDTH-1:0] cur,
    input logic [OFFS_WIDTH-1:0] offs
  );
    logic [SHIFT_WIDTH-1:0] shr;
    logic [SHIFT_WIDTH-1:0] shl;
    shr = SHIFT_WIDTH'(offs) << 3;            // 8 x offset
    shl = SHIFT_WIDTH'(DATA_WIDTH) - shr;     // 8 x (4 - offset)
    merge_words = (held >> shr) | (cur << shl);
  endfunction

  assign head_valid = ~rsp_empty_i & ~side_empty_i;
  assign head_last  = side_i.last & ~side_i.flush; // with flush the final beat comes later

  always_comb begin
    pop_o           = 1'b0;
    out_valid_o     = 1'b0;
    out_beat_o.data = '0;
    out_beat_o.strb = '1;
    out_beat_o.last = 1'b0;
    if (flush_pend_q) begin
      // tail bytes all sit in the held word
      out_valid_o     = 1'b1;
      out_beat_o.data = merge_words(prev_q, '0, flush_offs_q);
      out_beat_o.strb = tail_strb_q;
      out_beat_o.last = 1'b1;
    end else if (head_valid) begin
      if (!side_i.emit) begin
        pop_o = 1'b1; // store only, no beat
      end else begin
        out_valid_o = 1'b1;
        if (side_i.offset == '0) begin
          out_beat_o.data = rsp_i.rdata; // aligned, no rotation
        end else begin
          out_beat_o.data = merge_words(prev_q, rsp_i.rdata, side_i.offset);
        end
        out_beat_o.strb = head_last ? side_i.tail_strb : '1;
        out_beat_o.last = head_last;
        pop_o           = out_ready_i; // word leaves with its beat
      end
    end
  end

  assign last_beat_o = out_valid_o & out_ready_i & out_beat_o.last;

  // held word and flush parameters
  always_ff @(posedge clk_i) begin
    if (pop_o) prev_q <= rsp_i.rdata;
    if (pop_o & side_i.flush) begin
      flush_offs_q <= side_i.offset;
      tail_strb_q  <= side_i.tail_strb;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_pend_q <= 1'b0;
    end else if (pop_o & side_i.flush) begin
      flush_pend_q <= 1'b1;           // beat shows up the next cycle
    end else if (flush_pend_q & out_ready_i) begin
      flush_pend_q <= 1'b0;           // flush beat handed off
    end
  end

endmodule

`default_nettype wire

/* hdl/stream_source.sv */
// top of the realigning stream source, joins controller, response and side queues and realigner
`default_nettype none
`timescale 1ns/1ps

module stream_source (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  // job
  input  wire logic                                 start_i,
  input  wire realign_pkg::job_cfg_t                cfg_i,
  output logic                                      busy_o,
  output logic                                      done_o,
  // memory port
  output logic                                      mem_req_o,
  output logic [realign_pkg::WORD_ADDR_WIDTH-1:0]   mem_addr_o,
  input  wire logic                                 mem_gnt_i,
  input  wire logic                                 mem_rvalid_i,
  input  wire realign_pkg::mem_rsp_t                mem_rsp_i,
  // output stream
  output logic                                      out_valid_o,
  output realign_pkg::stream_beat_t                 out_beat_o,
  input  wire logic                                 out_ready_i
);
  import realign_pkg::*;

  logic       side_push;  // one record per granted read
  side_info_t side_in;
  side_info_t side_head;
  logic       side_empty;
  mem_rsp_t   rsp_head;
  logic       rsp_empty;
  logic       word_pop;   // realigner consumed head word and record
  logic       last_beat;

  source_ctrl source_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_gnt_i   (mem_gnt_i),
    .side_push_o (side_push),
    .side_o      (side_in),
    .pop_i       (word_pop),
    .last_beat_i (last_beat),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // responses cannot stall, credits keep this from filling past depth
  beat_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(mem_rsp_t)) rsp_queue_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (mem_rvalid_i),
    .data_i  (mem_rsp_i),
    .pop_i   (word_pop),
    .data_o  (rsp_head),
    .empty_o (rsp_empty),
    .full_o  ()
  );

  beat_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(side_info_t)) side_queue_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (side_push),
    .data_i  (side_in),
    .pop_i   (word_pop),
    .data_o  (side_head),
    .empty_o (side_empty),
    .full_o  ()
  );

  stream_realigner stream_realigner_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_empty_i  (rsp_empty),
    .rsp_i        (rsp_head),
    .side_empty_i (side_empty),
    .side_i       (side_head),
    .pop_o        (word_pop),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o),
    .out_ready_i  (out_ready_i),
    .last_beat_o  (last_beat)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the stream source testbench with Verilator, runs it and judges the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=stream_source_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
  -f filelist.f -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

/* verification/stream_source_stim.txt */
// memory image at 0x000, four words per row, byte value equals its byte address
// jobs at 0x040 as count then base, len_bytes, beats; beats at 0x080 as masked data, strb*16+last
@000
03020100 07060504 0b0a0908 0f0e0d0c
13121110 17161514 1b1a1918 1f1e1d1c
23222120 27262524 2b2a2928 2f2e2d2c
33323130 37363534 3b3a3938 3f3e3d3c
43424140 47464544 4b4a4948 4f4e4d4c
53525150 57565554 5b5a5958 5f5e5d5c
63626160 67666564 6b6a6968 6f6e6d6c
73727170 77767574 7b7a7978 7f7e7d7c
83828180 87868584 8b8a8988 8f8e8d8c
93929190 97969594 9b9a9998 9f9e9d9c
a3a2a1a0 a7a6a5a4 abaaa9a8 afaeadac
b3b2b1b0 b7b6b5b4 bbbab9b8 bfbebdbc
c3c2c1c0 c7c6c5c4 cbcac9c8 cfcecdcc
d3d2d1d0 d7d6d5d4 dbdad9d8 dfdedddc
e3e2e1e0 e7e6e5e4 ebeae9e8 efeeedec
f3f2f1f0 f7f6f5f4 fbfaf9f8 fffefdfc
@040
00000008
00000000 00000010 00000004 // aligned, full beats
00000021 00000008 00000002 // offset 1, one extra read
00000042 0000000a 00000003 // offset 2, flush beat
00000063 00000005 00000002 // offset 3, flush beat
00000080 00000007 00000002 // aligned, partial tail
000000a1 00000001 00000001 // single byte, flush only
000000c6 0000000d 00000004 // offset 2, flush beat
000000f4 0000000c 00000003 // aligned, ends at the top word
@080
03020100 f0 07060504 f0 0b0a0908 f0 0f0e0d0c f1
24232221 f0 28272625 f1
45444342 f0 49484746 f0 00004b4a 31
66656463 f0 00000067 11
83828180 f0 00868584 71
000000a1 11
c9c8c7c6 f0 cdcccbca f0 d1d0cfce f0 000000d2 11
f7f6f5f4 f0 fbfaf9f8 f0 fffefdfc f1

/* verification/stream_source_checks.svh */
// compare tasks and error counters included in the stream source testbench top module
`ifndef STREAM_SOURCE_CHECKS_SVH
`define STREAM_SOURCE_CHECKS_SVH

int unsigned beat_errors = 0;
int unsigned done_errors = 0;
int unsigned busy_errors = 0;

// lanes outside the strobe carry no data and compare as zero
task automatic check_beat(input stream_beat_t got, input stream_beat_t exp_beat,
                          input int unsigned idx);
  stream_beat_t got_m;
  got_m = got;
  for (int i = 0; i < STRB_WIDTH; i++) begin
    if (!got.strb[i]) got_m.data[8*i +: 8] = 8'h00; // lane not valid
  end
  if (got_m !== exp_beat) begin
    beat_errors++;
    $display("error at %0t: beat %0d got %h/%h/%b, expected %h/%h/%b", $time, idx,
             got_m.data, got_m.strb, got_m.last, exp_beat.data, exp_beat.strb, exp_beat.last);
  end
endtask

task automatic check_done(input int unsigned got, input int unsigned exp_cnt,
                          input int unsigned job);
  if (got != exp_cnt) begin
    done_errors++;
    $display("error at %0t: job %0d sees %0d done pulses, expected %0d", $time, job, got, exp_cnt);
  end
endtask

// busy level against the job phase
task automatic verify_busy(input logic got, input logic exp_lvl, input int unsigned job);
  if (got !== exp_lvl) begin
    busy_errors++;
    $display("error at %0t: job %0d busy %b, expected %b", $time, job, got, exp_lvl);
  end
endtask

`endif

/* verification/stream_source_tb.sv */
// testbench for the stream source that runs the stim file jobs against a random memory and sink
`default_nettype none
`timescale 1ns/1ps

module stream_source_tb;
  import realign_pkg::*;

  localparam int unsigned JOB_BASE   = 'h40;  // job count, then base, length, beats per job
  localparam int unsigned BEAT_BASE  = 'h80;  // data and strb/last pairs of all jobs in a row
  localparam int unsigned MEM_WORDS  = 64;    // words in the memory image
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned TIMEOUT    = 2000;  // cycles per wait

  logic                       clk;
  logic                       rst_n;
  logic                       start;
  job_cfg_t                   cfg;
  logic                       busy;
  logic                       done;
  logic                       mem_req;
  logic [WORD_ADDR_WIDTH-1:0] mem_addr;
  logic                       mem_gnt;
  logic                       mem_rvalid;
  mem_rsp_t                   mem_rsp;
  logic                       out_valid;
  stream_beat_t               out_beat;
  logic                       out_ready;

  logic [31:0]  stim [0:255];       // memory image, jobs and expected beats
  stream_beat_t got_q [$];          // output beats in arrival order
  int unsigned  rsp_due_q [$];      // answer cycle per granted read
  logic [31:0]  rsp_data_q [$];
  int unsigned  cycle_cnt;
  int unsigned  last_due;
  int unsigned  done_cnt     = 0;
  int unsigned  proto_errors = 0;
  bit           hold_valid;         // beat stalled in the cycle before
  stream_beat_t hold_beat;
  bit           timed_out    = 1'b0;

  `include "stream_source_checks.svh"

  stream_source stream_source_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .start_i      (start),
    .cfg_i        (cfg),
    .busy_o       (busy),
    .done_o       (done),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rsp_i    (mem_rsp),
    .out_valid_o  (out_valid),
    .out_beat_o   (out_beat),
    .out_ready_i  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // random grants with in-order answers 1 to 3 cycles after each grant
  always @(posedge clk) begin : mem_model
    int unsigned due;
    if (!rst_n) begin
      mem_gnt    <= 1'b0;
      mem_rvalid <= 1'b0;
      mem_rsp    <= '0;
      cycle_cnt  = 0;
      last_due   = 0;
      rsp_due_q.delete();
      rsp_data_q.delete();
    end else begin
      cycle_cnt = cycle_cnt + 1;
      mem_gnt <= ($urandom % 4) != 0;
      if (mem_req && mem_gnt) begin
        if (mem_addr >= WORD_ADDR_WIDTH'(MEM_WORDS)) begin
          proto_errors++;
          $display("memory read outside the image at word %0h, at %0t", mem_addr, $time);
        end
        due = cycle_cnt + 1 + ($urandom % 3);
        if (due <= last_due) due = last_due + 1; // keep request order
        last_due = due;
        rsp_due_q.push_back(due);
        rsp_data_q.push_back(stim[mem_addr[7:0]]);
      end
      mem_rvalid <= 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] == cycle_cnt) begin
        mem_rvalid    <= 1'b1;
        mem_rsp.rdata <= rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) out_ready <= 1'b0;
    else        out_ready <= ($urandom % 3) != 0; // sink stalls about a third of the time
  end

  // handshakes, done pulses and a stalled beat that must hold
  always @(posedge clk) begin
    if (!rst_n) begin
      hold_valid = 1'b0;
    end else begin
      if (hold_valid && (!out_valid || out_beat !== hold_beat)) begin
        proto_errors++;
        $display("output beat changed or lost valid while stalled, at %0t", $time);
      end
      if (out_valid && out_ready) got_q.push_back(out_beat);
      if (done) begin
        done_cnt++;
        verify_busy(busy, 1'b0, done_cnt - 1); // busy drops with the done pulse
      end
      hold_valid = out_valid && !out_ready;
      hold_beat  = out_beat;
    end
  end

  task automatic until_idle();
    int unsigned n;
    n = 0;
    while (busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      timed_out = 1'b1;
      $display("timeout: DUT still busy after %0d cycles at %0t", TIMEOUT, $time);
    end
  endtask

  task automatic fetch_beat(output stream_beat_t beat);
    int unsigned n;
    n    = 0;
    beat = '0;
    while (got_q.size() == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (got_q.size() == 0) begin
      timed_out = 1'b1;
      $display("timeout: no output beat within %0d cycles at %0t", TIMEOUT, $time);
    end else begin
      beat = got_q.pop_front();
    end
  endtask

  task automatic await_done(input int unsigned target);
    int unsigned n;
    n = 0;
    while (done_cnt < target && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (done_cnt < target) begin
      timed_out = 1'b1;
      $display("timeout: done pulse missing after %0d cycles at %0t", TIMEOUT, $time);
    end
  endtask

  initial begin
    int unsigned  njobs;
    int unsigned  nbeats;
    int unsigned  bidx;
    stream_beat_t got;
    stream_beat_t exp_beat;

    void'($urandom(32'h5209));
    $readmemh("verification/stream_source_stim.txt", stim);
    rst_n      <= 1'b0;
    start      <= 1'b0;
    cfg        <= '0;
    mem_gnt    <= 1'b0;
    mem_rvalid <= 1'b0;
    mem_rsp    <= '0;
    out_ready  <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    njobs = stim[JOB_BASE];
    bidx  = BEAT_BASE;
    for (int unsigned j = 0; j < njobs && !timed_out; j++) begin
      until_idle();
      if (timed_out) break;
      @(posedge clk);
      start         <= 1'b1;
      cfg.base      <= stim[JOB_BASE + 1 + 3*j][ADDR_WIDTH-1:0];
      cfg.len_bytes <= stim[JOB_BASE + 2 + 3*j][LEN_WIDTH-1:0];
      @(posedge clk);
      start  <= 1'b0;                       // one cycle pulse
      nbeats = stim[JOB_BASE + 3 + 3*j];
      @(negedge clk);
      verify_busy(busy, 1'b1, j);           // job taken on the start edge
      for (int unsigned k = 0; k < nbeats; k++) begin
        fetch_beat(got);
        if (timed_out) break;
        exp_beat.data = stim[bidx];
        exp_beat.strb = stim[bidx + 1][7:4];
        exp_beat.last = stim[bidx + 1][0];
        check_beat(got, exp_beat, (bidx - BEAT_BASE) / 2);
        bidx += 2;
      end
      if (!timed_out) begin
        check_done(done_cnt, j, j);         // nothing before the last beat
        await_done(j + 1);
        check_done(done_cnt, j + 1, j);
      end
    end

    if (!timed_out) begin
      repeat (20) @(negedge clk);           // idle tail where no stray done or beat may appear
      check_done(done_cnt, njobs, njobs);
      if (got_q.size() != 0) begin
        proto_errors++;
        $display("%0d output beats arrived beyond the expected ones", got_q.size());
      end
    end

    $display("errors: beat %0d, done %0d, busy %0d, protocol %0d, timeout %0d",
             beat_errors, done_errors, busy_errors, proto_errors, timed_out);
    if (beat_errors + done_errors + busy_errors + proto_errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
